//--- hdl/cache_pkg.sv
/*
 * Shared widths, types and encodings of the 2-way write-through cache.
 * Modules refer to these by scoped name (cache_pkg::name).
 */
`default_nettype none

package cache_pkg;

  // cpu word address, byte address bits 28..1
  localparam int ADDR_W     = 28;
  localparam int OFFSET_W   = 2;
  localparam int INDEX_W    = 8;
  localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;
  localparam int WAY_ADDR_W = INDEX_W + OFFSET_W;

  // field positions inside cpu_adr
  localparam int INDEX_LSB = OFFSET_W;
  localparam int TAG_LSB   = OFFSET_W + INDEX_W;

  typedef logic [15:0] word_t;
  // bit 0 selects the low byte
  typedef logic [1:0]  byte_sel_t;

  // lru = 1 makes way 0 the next victim
  typedef struct packed {
    logic             lru;
    logic             valid1;
    logic             valid0;
    logic [TAG_W-1:0] tag1;
    logic [TAG_W-1:0] tag0;
  } tag_entry_t;

  // source of a tag write
  localparam logic [1:0] TAG_SEL_REFRESH = 2'd0;
  localparam logic [1:0] TAG_SEL_FILL    = 2'd1;
  localparam logic [1:0] TAG_SEL_CLEAR   = 2'd2;

  // source of a way write
  localparam logic WDATA_CPU = 1'b0;
  localparam logic WDATA_SDR = 1'b1;

  typedef enum logic [3:0] {
    CLEAR,
    IDLE,
    WRITE,
    WRITE_HOLD,
    READ,
    READ_HOLD,
    FILL_FIRST,
    FILL_REST,
    FILL_HOLD
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- hdl/cache_ram.sv
/*
 * Synchronous single-port RAM with registered read, written in whole
 * entries. The entry type is a parameter, so the same block holds tags
 * and data words.
 */
`timescale 1ns/1ps
`default_nettype none

module cache_ram #(
  parameter type entry_t   = logic [15:0],
  parameter int  ADDR_BITS = 8
) (
  input  wire                 clk,
  input  wire [ADDR_BITS-1:0] addr,
  input  wire                 we,
  input  wire entry_t         wdata,
  output entry_t              rdata
);

  entry_t mem [2**ADDR_BITS];

  // read returns the old entry when written in the same cycle
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];
  end

  // once the controller is out of reset the write enable stays defined
  a_we_known: assert property (@(posedge clk) !$isunknown($past(we)) |-> !$isunknown(we))
    else $error("cache_ram: write enable went unknown");

endmodule

`default_nettype wire

//--- hdl/line_counter.sv
/*
 * Loadable up-counter. It sweeps tag rows during a clear; its low bits
 * step the word offset of a line fill. last marks the final step.
 */
`timescale 1ns/1ps
`default_nettype none

module line_counter #(
  parameter int WIDTH = 8
) (
  input  wire              clk,
  input  wire              rst,
  input  wire              start,
  input  wire [WIDTH-1:0]  load_value,
  input  wire              step,
  output logic [WIDTH-1:0] count,
  output logic             last
);

  // steps taken since the last start
  logic [WIDTH-1:0] steps;

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
      steps <= '0;
    end else if (start) begin
      count <= load_value;
      steps <= '0;
    end else if (step) begin
      count <= count + 1'b1;
      steps <= steps + 1'b1;
    end
  end

  assign last = &steps;

  a_start_step: assert property (@(posedge clk) disable iff (rst) !(start && step))
    else $error("line_counter: start and step together");

endmodule

`default_nettype wire

//--- hdl/tag_check.sv
/*
 * Tag store of the cache. Compares both ways against the address tag
 * and builds the entry written back on an lru refresh, a line fill or a
 * clear. Outputs follow the index by one cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module tag_check #(
  parameter int INDEX_W = 8,
  parameter int TAG_W   = 18
) (
  input  wire               clk,
  input  wire [INDEX_W-1:0] index,
  input  wire [TAG_W-1:0]   addr_tag,
  input  wire               tag_we,
  input  wire [1:0]         tag_sel,
  input  wire               fill_way,
  output logic              hit,
  output logic              hit_way,
  output logic              victim_way
);

  cache_pkg::tag_entry_t rd_entry;
  cache_pkg::tag_entry_t wr_entry;
  logic                  hit0;
  logic                  hit1;

  cache_ram #(
    .entry_t   (cache_pkg::tag_entry_t),
    .ADDR_BITS (INDEX_W)
  ) tag_ram (
    .clk   (clk),
    .addr  (index),
    .we    (tag_we),
    .wdata (wr_entry),
    .rdata (rd_entry)
  );

  assign hit0       = rd_entry.valid0 && (rd_entry.tag0 == addr_tag);
  assign hit1       = rd_entry.valid1 && (rd_entry.tag1 == addr_tag);
  assign hit        = hit0 || hit1;
  // way 0 wins if both match
  assign hit_way    = hit1 && !hit0;
  assign victim_way = !rd_entry.lru;

  // lru always ends up naming the way just used
  always_comb begin
    wr_entry = rd_entry;
    case (tag_sel)
      cache_pkg::TAG_SEL_REFRESH: begin
        wr_entry.lru = hit_way;
      end
      cache_pkg::TAG_SEL_FILL: begin
        wr_entry.lru = fill_way;
        if (fill_way) begin
          wr_entry.tag1   = addr_tag;
          wr_entry.valid1 = 1'b1;
        end else begin
          wr_entry.tag0   = addr_tag;
          wr_entry.valid0 = 1'b1;
        end
      end
      default: begin
        wr_entry = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/way_data_path.sv
/*
 * Data ways of the cache. Picks the RAM address (cpu word or fill word),
 * merges cpu byte writes into the stored word and returns the word of
 * the selected way one cycle after the address.
 */
`timescale 1ns/1ps
`default_nettype none

module way_data_path #(
  parameter int WAY_ADDR_W = 10
) (
  input  wire                            clk,
  input  wire [WAY_ADDR_W-1:0]           cpu_addr,
  input  wire                            fill_active,
  input  wire [cache_pkg::OFFSET_W-1:0]  fill_offset,
  input  wire [1:0]                      way_we,
  input  wire                            wdata_sel,
  input  wire cache_pkg::byte_sel_t      cpu_bs,
  input  wire cache_pkg::word_t          cpu_dat_w,
  input  wire cache_pkg::word_t          sdr_dat_r,
  input  wire                            read_way,
  output cache_pkg::word_t               rdata
);

  logic [WAY_ADDR_W-1:0] ram_addr;
  cache_pkg::word_t      way_rdata [2];
  cache_pkg::word_t      merged;
  cache_pkg::word_t      ram_wdata;

  // a fill keeps the row and walks the word offset
  assign ram_addr = fill_active ?
                    {cpu_addr[WAY_ADDR_W-1:cache_pkg::OFFSET_W], fill_offset} :
                    cpu_addr;

  assign rdata = way_rdata[read_way];

  // unselected bytes keep what the hitting way holds
  always_comb begin
    merged[7:0]  = cpu_bs[0] ? cpu_dat_w[7:0]  : rdata[7:0];
    merged[15:8] = cpu_bs[1] ? cpu_dat_w[15:8] : rdata[15:8];
  end

  assign ram_wdata = (wdata_sel == cache_pkg::WDATA_SDR) ? sdr_dat_r : merged;

  for (genvar w = 0; w < 2; w++) begin : g_way
    cache_ram #(
      .entry_t   (cache_pkg::word_t),
      .ADDR_BITS (WAY_ADDR_W)
    ) way_ram (
      .clk   (clk),
      .addr  (ram_addr),
      .we    (way_we[w]),
      .wdata (ram_wdata),
      .rdata (way_rdata[w])
    );
  end

endmodule

`default_nettype wire

//--- hdl/cache_fsm.sv
/*
 * Cache controller. Serves cpu reads and write-through writes, runs the
 * four-word line fill from sdram and sweeps the tag store on reset and
 * on a clear request. Holds the cache-enable and clear-edge registers.
 */
`timescale 1ns/1ps
`default_nettype none

module cache_fsm (
  input  wire                    clk,
  input  wire                    rst,
  input  wire                    cpu_cs,
  input  wire                    cpu_we,
  input  wire [3:0]              cpu_cache_ctrl,
  input  wire                    cache_inhibit,
  input  wire                    hit,
  input  wire                    hit_way,
  input  wire                    victim_way,
  input  wire                    sdr_read_ack,
  input  wire cache_pkg::word_t  sdr_dat_r,
  input  wire cache_pkg::word_t  way_rdata,
  input  wire                    count_last,
  output logic                   cpu_ack,
  output cache_pkg::word_t       cpu_dat_r,
  output logic                   wb_en,
  output logic                   sdr_read_req,
  output logic                   tag_we,
  output logic [1:0]             tag_sel,
  output logic                   fill_way,
  output logic [1:0]             way_we,
  output logic                   fill_active,
  output logic                   wdata_sel,
  output logic                   read_way,
  output logic                   count_start,
  output logic                   count_step
);

  cache_pkg::ctrl_state_t state;
  logic                   cc_en;
  logic [1:0]             clr_q;
  logic                   clear_edge;
  logic                   clr_pend;
  // line goes into the cache at all
  logic                   store;
  // words still to come after the first
  logic [1:0]             fill_left;

  assign clear_edge = clr_q[0] && !clr_q[1];

  // the hitting way is read back on reads and merged on writes
  assign read_way = hit_way;

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= cache_pkg::CLEAR;
      cpu_ack      <= 1'b0;
      wb_en        <= 1'b0;
      sdr_read_req <= 1'b0;
      cc_en        <= 1'b0;
      clr_q        <= 2'b00;
      clr_pend     <= 1'b0;
      fill_way     <= 1'b0;
      store        <= 1'b0;
      fill_left    <= 2'd0;
    end else begin
      wb_en <= 1'b0;
      // control bits only move between accesses
      if (!cpu_cs) begin
        cc_en <= cpu_cache_ctrl[0];
        clr_q <= {clr_q[0], cpu_cache_ctrl[3]};
      end
      if (clear_edge && !cpu_cs) begin
        clr_pend <= 1'b1;
      end else if (state == cache_pkg::CLEAR) begin
        clr_pend <= 1'b0;
      end
      case (state)
        cache_pkg::CLEAR: begin
          if (count_last) state <= cache_pkg::IDLE;
        end
        cache_pkg::IDLE: begin
          // a pending clear goes before the next access
          if (clr_pend) begin
            state <= cache_pkg::CLEAR;
          end else if (cpu_cs) begin
            state <= cpu_we ? cache_pkg::WRITE : cache_pkg::READ;
          end
        end
        cache_pkg::WRITE: begin
          wb_en <= 1'b1;
          state <= cpu_cs ? cache_pkg::WRITE_HOLD : cache_pkg::IDLE;
        end
        cache_pkg::WRITE_HOLD: begin
          wb_en <= cpu_cs;
          if (!cpu_cs) state <= cache_pkg::IDLE;
        end
        cache_pkg::READ: begin
          if (cc_en && hit) begin
            cpu_dat_r <= way_rdata;
            state     <= cache_pkg::READ_HOLD;
          end else begin
            sdr_read_req <= 1'b1;
            fill_way     <= victim_way;
            store        <= cc_en && !cache_inhibit;
            fill_left    <= 2'd3;
            state        <= cache_pkg::FILL_FIRST;
          end
        end
        cache_pkg::READ_HOLD: begin
          cpu_ack <= cpu_cs;
          if (!cpu_cs) state <= cache_pkg::IDLE;
        end
        cache_pkg::FILL_FIRST: begin
          // requested word goes straight to the cpu
          if (sdr_read_ack) begin
            sdr_read_req <= 1'b0;
            cpu_dat_r    <= sdr_dat_r;
            cpu_ack      <= 1'b1;
            state        <= cache_pkg::FILL_REST;
          end
        end
        cache_pkg::FILL_REST: begin
          if (sdr_read_ack) begin
            fill_left <= fill_left - 2'd1;
            if (fill_left == 2'd1) state <= cache_pkg::FILL_HOLD;
          end
        end
        cache_pkg::FILL_HOLD: begin
          if (!cpu_ack) state <= cache_pkg::IDLE;
        end
        default: begin
          state <= cache_pkg::IDLE;
        end
      endcase
      // ack drops on the first edge that sees cs low
      if (!cpu_cs) cpu_ack <= 1'b0;
    end
  end

  always_comb begin
    tag_we      = 1'b0;
    tag_sel     = cache_pkg::TAG_SEL_REFRESH;
    way_we      = 2'b00;
    fill_active = 1'b0;
    wdata_sel   = cache_pkg::WDATA_CPU;
    count_start = 1'b0;
    count_step  = 1'b0;
    case (state)
      cache_pkg::CLEAR: begin
        tag_we     = 1'b1;
        tag_sel    = cache_pkg::TAG_SEL_CLEAR;
        count_step = 1'b1;
      end
      cache_pkg::IDLE: begin
        count_start = clr_pend;
      end
      cache_pkg::WRITE: begin
        // keep a cached copy current even with the cache disabled
        if (hit) way_we = hit_way ? 2'b10 : 2'b01;
      end
      cache_pkg::READ: begin
        // hit refreshes lru, miss loads the requested offset
        if (cc_en && hit) begin
          tag_we = 1'b1;
        end else begin
          count_start = 1'b1;
        end
      end
      cache_pkg::FILL_FIRST, cache_pkg::FILL_REST: begin
        fill_active = 1'b1;
        wdata_sel   = cache_pkg::WDATA_SDR;
        count_step  = sdr_read_ack;
        if (sdr_read_ack && store) way_we = fill_way ? 2'b10 : 2'b01;
        if (state == cache_pkg::FILL_FIRST) begin
          tag_we  = sdr_read_ack && store;
          tag_sel = cache_pkg::TAG_SEL_FILL;
        end
      end
      default: begin
      end
    endcase
  end

  a_ack_release: assert property (@(posedge clk) disable iff (rst)
    $fell(cpu_cs) |=> !cpu_ack)
    else $error("cache_fsm: cpu_ack held after cpu_cs fell");

  a_one_way: assert property (@(posedge clk) disable iff (rst) !(&way_we))
    else $error("cache_fsm: both ways written at once");

endmodule

`default_nettype wire

//--- hdl/cpu_cache.sv
/*
 * 2-way set-associative write-through cache between a 16-bit cpu bus
 * and an sdram read port. Tags are cleared after reset and on a rising
 * edge of cpu_cache_ctrl[3]; bit 0 enables the cache.
 */
`timescale 1ns/1ps
`default_nettype none

module cpu_cache (
  input  wire                          clk,
  input  wire                          rst,
  input  wire [3:0]                    cpu_cache_ctrl,
  input  wire                          cache_inhibit,
  input  wire                          cpu_cs,
  input  wire [cache_pkg::ADDR_W-1:0]  cpu_adr,
  input  wire cache_pkg::byte_sel_t    cpu_bs,
  input  wire                          cpu_we,
  input  wire cache_pkg::word_t        cpu_dat_w,
  output cache_pkg::word_t             cpu_dat_r,
  output logic                         cpu_ack,
  output logic                         wb_en,
  input  wire cache_pkg::word_t        sdr_dat_r,
  output logic                         sdr_read_req,
  input  wire                          sdr_read_ack
);

  logic                          hit;
  logic                          hit_way;
  logic                          victim_way;
  logic                          tag_we;
  logic [1:0]                    tag_sel;
  logic                          fill_way;
  logic [1:0]                    way_we;
  logic                          fill_active;
  logic                          wdata_sel;
  logic                          read_way;
  logic                          count_start;
  logic                          count_step;
  logic                          count_last;
  logic [cache_pkg::INDEX_W-1:0] count;
  cache_pkg::word_t              way_rdata;

  // tag row comes from the counter while clearing
  wire [cache_pkg::INDEX_W-1:0] tag_index = (tag_sel == cache_pkg::TAG_SEL_CLEAR) ?
                                            count :
                                            cpu_adr[cache_pkg::INDEX_LSB +: cache_pkg::INDEX_W];

  // a fill starts at the requested word, a clear sweeps all rows from anywhere
  wire [cache_pkg::INDEX_W-1:0] load_value =
    {{(cache_pkg::INDEX_W - cache_pkg::OFFSET_W){1'b0}}, cpu_adr[cache_pkg::OFFSET_W-1:0]};

  cache_fsm cache_fsm_inst (
    .clk            (clk),
    .rst            (rst),
    .cpu_cs         (cpu_cs),
    .cpu_we         (cpu_we),
    .cpu_cache_ctrl (cpu_cache_ctrl),
    .cache_inhibit  (cache_inhibit),
    .hit            (hit),
    .hit_way        (hit_way),
    .victim_way     (victim_way),
    .sdr_read_ack   (sdr_read_ack),
    .sdr_dat_r      (sdr_dat_r),
    .way_rdata      (way_rdata),
    .count_last     (count_last),
    .cpu_ack        (cpu_ack),
    .cpu_dat_r      (cpu_dat_r),
    .wb_en          (wb_en),
    .sdr_read_req   (sdr_read_req),
    .tag_we         (tag_we),
    .tag_sel        (tag_sel),
    .fill_way       (fill_way),
    .way_we         (way_we),
    .fill_active    (fill_active),
    .wdata_sel      (wdata_sel),
    .read_way       (read_way),
    .count_start    (count_start),
    .count_step     (count_step)
  );

  line_counter #(
    .WIDTH (cache_pkg::INDEX_W)
  ) line_counter_inst (
    .clk        (clk),
    .rst        (rst),
    .start      (count_start),
    .load_value (load_value),
    .step       (count_step),
    .count      (count),
    .last       (count_last)
  );

  tag_check #(
    .INDEX_W (cache_pkg::INDEX_W),
    .TAG_W   (cache_pkg::TAG_W)
  ) tag_check_inst (
    .clk        (clk),
    .index      (tag_index),
    .addr_tag   (cpu_adr[cache_pkg::TAG_LSB +: cache_pkg::TAG_W]),
    .tag_we     (tag_we),
    .tag_sel    (tag_sel),
    .fill_way   (fill_way),
    .hit        (hit),
    .hit_way    (hit_way),
    .victim_way (victim_way)
  );

  way_data_path #(
    .WAY_ADDR_W (cache_pkg::WAY_ADDR_W)
  ) way_data_path_inst (
    .clk         (clk),
    .cpu_addr    (cpu_adr[cache_pkg::WAY_ADDR_W-1:0]),
    .fill_active (fill_active),
    .fill_offset (count[cache_pkg::OFFSET_W-1:0]),
    .way_we      (way_we),
    .wdata_sel   (wdata_sel),
    .cpu_bs      (cpu_bs),
    .cpu_dat_w   (cpu_dat_w),
    .sdr_dat_r   (sdr_dat_r),
    .read_way    (read_way),
    .rdata       (way_rdata)
  );

endmodule

`default_nettype wire

//--- sim/sdram_model.sv
/*
 * Behavioral sdram read port for the cache testbench. A request returns
 * four words of the line, the requested word first, as one-cycle
 * acknowledge pulses with a random gap of 0 to 3 cycles between them.
 */
`timescale 1ns/1ps
`default_nettype none

module sdram_model #(
  parameter logic [31:0] SEED = 32'hb4ff
) (
  input  wire                         clk,
  input  wire                         rst,
  input  wire                         read_req,
  input  wire [cache_pkg::ADDR_W-1:0] adr,
  output logic                        read_ack,
  output cache_pkg::word_t            dat_r,
  output logic                        busy
);

  logic [31:0]                 lfsr;
  logic [1:0]                  gap;
  logic [1:0]                  wait_cnt;
  logic [1:0]                  n;
  logic [cache_pkg::ADDR_W-1:0] base;

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // stored word is a fixed mix of its full word address
  function automatic cache_pkg::word_t word_at(input logic [cache_pkg::ADDR_W-1:0] a);
    return a[15:0] ^ {a[27:16], 4'h9};
  endfunction

  // one lfsr step per bit taken
  task automatic draw_gap();
    lfsr   = lfsr_next(lfsr);
    gap[0] = lfsr[0];
    lfsr   = lfsr_next(lfsr);
    gap[1] = lfsr[0];
  endtask

  always @(posedge clk) begin
    if (rst) begin
      lfsr = SEED;
      read_ack <= 1'b0;
      dat_r    <= '0;
      busy     <= 1'b0;
      wait_cnt <= '0;
      n        <= '0;
      base     <= '0;
    end else begin
      read_ack <= 1'b0;
      if (!busy) begin
        if (read_req) begin
          draw_gap();
          busy     <= 1'b1;
          base     <= adr;
          n        <= '0;
          wait_cnt <= gap;
        end
      end else if (wait_cnt != 2'd0) begin
        wait_cnt <= wait_cnt - 2'd1;
      end else begin
        read_ack <= 1'b1;
        // offsets wrap inside the line
        dat_r    <= word_at({base[cache_pkg::ADDR_W-1:2], base[1:0] + n});
        n        <= n + 2'd1;
        if (n == 2'd3) begin
          busy <= 1'b0;
        end else begin
          draw_gap();
          wait_cnt <= gap;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- sim/cpu_cache_tb.sv
/*
 * Table-driven testbench of the cache. Each row is one cpu access with
 * its control bits, expected word and expected miss flag.
 */
`timescale 1ns/1ps
`default_nettype none

module cpu_cache_tb;

  localparam int N_ROWS = 23;
  localparam int OP_RD  = 0;
  localparam int OP_WR  = 1;
  localparam int OP_CLR = 2;

  logic                         clk = 1'b0;
  logic                         rst = 1'b1;
  logic [3:0]                   cpu_cache_ctrl = 4'h0;
  logic                         cache_inhibit = 1'b0;
  logic                         cpu_cs = 1'b0;
  logic [cache_pkg::ADDR_W-1:0] cpu_adr = '0;
  cache_pkg::byte_sel_t         cpu_bs = 2'b11;
  logic                         cpu_we = 1'b0;
  cache_pkg::word_t             cpu_dat_w = '0;
  cache_pkg::word_t             cpu_dat_r;
  logic                         cpu_ack;
  logic                         wb_en;
  cache_pkg::word_t             sdr_dat_r;
  logic                         sdr_read_req;
  logic                         sdr_read_ack;
  logic                         sdr_busy;

  // stimulus and expected values, one row per access
  int                           t_op   [N_ROWS];
  logic [cache_pkg::ADDR_W-1:0] t_adr  [N_ROWS];
  cache_pkg::byte_sel_t         t_bs   [N_ROWS];
  cache_pkg::word_t             t_dat  [N_ROWS];
  logic                         t_en   [N_ROWS];
  logic                         t_inh  [N_ROWS];
  logic                         t_clr  [N_ROWS];
  cache_pkg::word_t             t_exp  [N_ROWS];
  logic                         t_miss [N_ROWS];
  int                           n_rows = 0;
  int                           word_errs = 0;
  int                           flag_errs = 0;
  int                           lat_errs = 0;

  always #20 clk = ~clk;

  cpu_cache cpu_cache_inst (
    .clk (clk), .rst (rst), .cpu_cache_ctrl (cpu_cache_ctrl),
    .cache_inhibit (cache_inhibit), .cpu_cs (cpu_cs), .cpu_adr (cpu_adr),
    .cpu_bs (cpu_bs), .cpu_we (cpu_we), .cpu_dat_w (cpu_dat_w),
    .cpu_dat_r (cpu_dat_r), .cpu_ack (cpu_ack), .wb_en (wb_en),
    .sdr_dat_r (sdr_dat_r), .sdr_read_req (sdr_read_req), .sdr_read_ack (sdr_read_ack)
  );

  sdram_model sdram_model (
    .clk (clk), .rst (rst), .read_req (sdr_read_req), .adr (cpu_adr),
    .read_ack (sdr_read_ack), .dat_r (sdr_dat_r), .busy (sdr_busy)
  );

  // value the sdram holds at a word address
  function automatic cache_pkg::word_t mem_word(input logic [cache_pkg::ADDR_W-1:0] a);
    return a[15:0] ^ {a[27:16], 4'h9};
  endfunction

  function automatic logic [cache_pkg::ADDR_W-1:0] line_adr(input logic [17:0] tag,
                                                           input logic [7:0] idx,
                                                           input logic [1:0] off);
    return {tag, idx, off};
  endfunction

  task automatic add_row(input int op, input logic [cache_pkg::ADDR_W-1:0] adr,
                         input cache_pkg::byte_sel_t bs, input cache_pkg::word_t dat,
                         input logic en, input logic inh, input logic clr,
                         input cache_pkg::word_t exp, input logic miss);
    t_op[n_rows] = op;
    t_adr[n_rows] = adr;
    t_bs[n_rows] = bs;
    t_dat[n_rows] = dat;
    t_en[n_rows] = en;
    t_inh[n_rows] = inh;
    t_clr[n_rows] = clr;
    t_exp[n_rows] = exp;
    t_miss[n_rows] = miss;
    n_rows++;
  endtask

  task automatic check_word(input int row, input cache_pkg::word_t got,
                            input cache_pkg::word_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: row %0d read %h, expected %h", $time, row, got, exp);
      word_errs++;
    end
  endtask

  task automatic check_flag(input int row, input string what, input logic got,
                            input logic exp);
    if (got !== exp) begin
      $display("** Error at %0t: row %0d %s is %b, expected %b", $time, row, what, got, exp);
      flag_errs++;
    end
  endtask

  task automatic check_latency(input int row, input int got, input int exp);
    if (got != exp) begin
      $display("** Error at %0t: row %0d ack after %0d cycles, expected %0d",
               $time, row, got, exp);
      lat_errs++;
    end
  endtask

  task automatic build_table();
    logic [cache_pkg::ADDR_W-1:0] l1;
    logic [cache_pkg::ADDR_W-1:0] u;
    logic [cache_pkg::ADDR_W-1:0] v;
    logic [cache_pkg::ADDR_W-1:0] x0;
    logic [cache_pkg::ADDR_W-1:0] x1;
    logic [cache_pkg::ADDR_W-1:0] x2;
    l1 = line_adr(18'h02af3, 8'h51, 2'd2);
    u  = line_adr(18'h00ccc, 8'hcc, 2'd0);
    v  = line_adr(18'h01dde, 8'he8, 2'd0);
    x0 = line_adr(18'h00011, 8'h40, 2'd1);
    x1 = line_adr(18'h00022, 8'h40, 2'd1);
    x2 = line_adr(18'h00033, 8'h40, 2'd1);
    // first read misses, the whole line then hits
    add_row(OP_RD, l1, 2'b11, 16'h0, 1, 0, 0, mem_word(l1), 1);
    for (int o = 0; o < 4; o++) begin
      add_row(OP_RD, {l1[27:2], 2'(o)}, 2'b11, 16'h0, 1, 0, 0,
              mem_word({l1[27:2], 2'(o)}), 0);
    end
    // low-byte write through, then an uncached write
    add_row(OP_WR, l1 ^ 28'd3, 2'b01, 16'h5aa5, 1, 0, 0, 16'h0, 0);
    add_row(OP_RD, l1 ^ 28'd3, 2'b11, 16'h0, 1, 0, 0,
            {8'(mem_word(l1 ^ 28'd3) >> 8), 8'ha5}, 0);
    add_row(OP_WR, u, 2'b11, 16'hdead, 1, 0, 0, 16'h0, 0);
    add_row(OP_RD, u, 2'b11, 16'h0, 1, 0, 0, mem_word(u), 1);
    // two ways at one index, lru picks the victim
    add_row(OP_RD, x0, 2'b11, 16'h0, 1, 0, 0, mem_word(x0), 1);
    add_row(OP_RD, x1, 2'b11, 16'h0, 1, 0, 0, mem_word(x1), 1);
    add_row(OP_RD, x0, 2'b11, 16'h0, 1, 0, 0, mem_word(x0), 0);
    add_row(OP_RD, x2, 2'b11, 16'h0, 1, 0, 0, mem_word(x2), 1);
    add_row(OP_RD, x0, 2'b11, 16'h0, 1, 0, 0, mem_word(x0), 0);
    add_row(OP_RD, x1, 2'b11, 16'h0, 1, 0, 0, mem_word(x1), 1);
    // inhibit and disable
    add_row(OP_RD, v, 2'b11, 16'h0, 1, 1, 0, mem_word(v), 1);
    add_row(OP_RD, v, 2'b11, 16'h0, 1, 1, 0, mem_word(v), 1);
    add_row(OP_RD, {l1[27:2], 2'd0}, 2'b11, 16'h0, 0, 0, 0, mem_word({l1[27:2], 2'd0}), 1);
    add_row(OP_RD, {l1[27:2], 2'd0}, 2'b11, 16'h0, 1, 0, 0, mem_word({l1[27:2], 2'd0}), 0);
    // clear edge drops every line
    add_row(OP_CLR, '0, 2'b11, 16'h0, 1, 0, 1, 16'h0, 0);
    add_row(OP_RD, {l1[27:2], 2'd3}, 2'b11, 16'h0, 1, 0, 0, mem_word({l1[27:2], 2'd3}), 1);
    add_row(OP_RD, x0, 2'b11, 16'h0, 1, 0, 0, mem_word(x0), 1);
    add_row(OP_RD, {l1[27:2], 2'd3}, 2'b11, 16'h0, 1, 0, 0, mem_word({l1[27:2], 2'd3}), 0);
  endtask

  task automatic run_row(input int r);
    int   cycles;
    logic miss_seen;
    logic wb_seen;
    cpu_cs = 1'b0;
    cpu_cache_ctrl = {t_clr[r], 2'b00, t_en[r]};
    cache_inhibit = t_inh[r];
    // control bits settle and a clear edge gets registered
    repeat (3) @(negedge clk);
    if (t_op[r] == OP_CLR) return;
    cpu_adr = t_adr[r];
    cpu_bs = t_bs[r];
    cpu_dat_w = t_dat[r];
    cpu_we = (t_op[r] == OP_WR);
    cpu_cs = 1'b1;
    cycles = 0;
    miss_seen = 1'b0;
    wb_seen = 1'b0;
    if (t_op[r] == OP_WR) begin
      repeat (4) begin
        @(negedge clk);
        wb_seen |= wb_en;
      end
      cpu_cs = 1'b0;
      check_flag(r, "wb_en", wb_seen, 1'b1);
      repeat (2) @(negedge clk);
      return;
    end
    do begin
      @(negedge clk);
      cycles++;
      miss_seen |= sdr_read_req;
    end while (!cpu_ack);
    check_word(r, cpu_dat_r, t_exp[r]);
    check_flag(r, "miss", miss_seen, t_miss[r]);
    if (!t_miss[r]) check_latency(r, cycles, 3);
    cpu_cs = 1'b0;
    // address stays put until the line fill is done
    while (cpu_ack || sdr_busy) @(negedge clk);
    repeat (3) @(negedge clk);
  endtask

  initial begin
    build_table();
    repeat (8) @(negedge clk);
    rst = 1'b0;
    for (int r = 0; r < n_rows; r++) run_row(r);
    $display("errors: %0d word, %0d flag, %0d latency", word_errs, flag_errs, lat_errs);
    if (word_errs + flag_errs + lat_errs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin
    repeat (N_ROWS * 300 + 264) @(posedge clk);
    $display("watchdog expired before all rows were applied");
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- cpu_cache.f
hdl/cache_pkg.sv
hdl/cache_ram.sv
hdl/line_counter.sv
hdl/tag_check.sv
hdl/way_data_path.sv
hdl/cache_fsm.sv
hdl/cpu_cache.sv
sim/sdram_model.sv
sim/cpu_cache_tb.sv

//--- Makefile
# Verilator build and run of the cache testbench
VERILATOR ?= verilator
TOP       ?= cpu_cache_tb
RTL_TOP   ?= cpu_cache
FILELIST  ?= cpu_cache.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
